// ==== source/modsq_settings.svh ====
`ifndef MODSQ_SETTINGS_SVH
`define MODSQ_SETTINGS_SVH

// limb geometry
`define MODSQ_BIT_LEN       17   // stored limb, one redundant bit over the radix
`define MODSQ_WORD_LEN      16   // radix width

// operand shape
`define MODSQ_NONRED_ELEMS  4    // 64 bits of modulus
`define MODSQ_NUM_ELEMS     6    // plus two redundant limbs
`define MODSQ_GRID_SIZE     12   // square spans twice the limbs

// reduction lookups
`define MODSQ_LUT_WIDTH     8    // lsb address, msb takes the remaining 9 bits
`define MODSQ_NUM_LUTS      8    // upper grid words folded back

// column sums carry headroom for the compressor chains
`define MODSQ_COL_BIT_LEN   29

// fixed odd modulus, the largest 64-bit prime
`define MODSQ_MODULUS       64'hFFFF_FFFF_FFFF_FFC5

`endif

// ==== source/modsq_pkg.sv ====
package modsq_pkg;
`include "modsq_settings.svh"

   // one redundant limb of an operand or result
   typedef logic [`MODSQ_BIT_LEN-1:0] limb_t;

   // carry or sum word of a grid or accumulator column
   typedef logic [`MODSQ_COL_BIT_LEN-1:0] col_t;

   // two table addresses carved out of one limb
   typedef struct packed {
      logic [`MODSQ_BIT_LEN-`MODSQ_LUT_WIDTH-1:0] msb;   // bits 16:8
      logic [`MODSQ_LUT_WIDTH-1:0]                lsb;   // bits 7:0
   } lut_index_t;

   // an upper grid word, read as a limb or as lookup addresses
   typedef union packed {
      limb_t      limb;
      lut_index_t idx;
   } limb_view_u;

endpackage

// ==== source/modsq_sequencer.sv ====
`timescale 1ns/10ps

module modsq_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic start,
   output logic msb_sel,
   output logic hold_lsb,
   output logic load_out,
   output logic use_input,
   output logic valid
);

   localparam int IDLE       = 0;
   localparam int C0         = 1;
   localparam int C1         = 2;
   localparam int C2         = 3;
   localparam int NUM_STATES = 4;

   logic [NUM_STATES-1:0] state;
   logic [NUM_STATES-1:0] next_state;

   // runs forever once started, only reset brings it back to idle
   always_comb begin
      next_state = '0;
      case (1'b1)
         state[IDLE]: begin
            if (start) begin
               next_state[C0] = 1'b1;
            end else begin
               next_state[IDLE] = 1'b1;
            end
         end
         state[C0]: next_state[C1] = 1'b1;   // lsb lookups issued
         state[C1]: next_state[C2] = 1'b1;   // msb lookups issued
         state[C2]: next_state[C0] = 1'b1;   // result loads, loop back
         default:   next_state[IDLE] = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= NUM_STATES'(1 << IDLE);
         use_input <= 1'b0;
         valid     <= 1'b0;
      end else begin
         state <= next_state;
         if (state[IDLE] && start) begin
            use_input <= 1'b1;   // first pass squares the captured operand
         end else if (state[C2]) begin
            use_input <= 1'b0;
         end
         valid <= load_out;
      end
   end

   assign msb_sel  = state[C1];
   assign hold_lsb = state[C1];   // lsb data is on the rom output during C1
   assign load_out = state[C2];

endmodule

// ==== source/squaring_grid.sv ====
`timescale 1ns/10ps
`include "modsq_settings.svh"

module squaring_grid import modsq_pkg::*; (
   input  limb_t a[`MODSQ_NUM_ELEMS],
   output col_t  col_c[`MODSQ_GRID_SIZE],
   output col_t  col_s[`MODSQ_GRID_SIZE]
);

   localparam int NUM_ELEMS = `MODSQ_NUM_ELEMS;
   localparam int GRID_SIZE = `MODSQ_GRID_SIZE;
   localparam int WORD_LEN  = `MODSQ_WORD_LEN;
   localparam int PROD_W    = 2 * `MODSQ_BIT_LEN;   // 34b product
   localparam int NUM_ROWS  = 2 * NUM_ELEMS;        // low and high half per row of a

   // row 2i holds low halves of a[i]*a[j], row 2i+1 the high halves
   col_t grid[GRID_SIZE][NUM_ROWS];

   always_comb begin
      logic [PROD_W-1:0] prod;
      for (int c = 0; c < GRID_SIZE; c++) begin
         for (int r = 0; r < NUM_ROWS; r++) begin
            grid[c][r] = '0;
         end
      end
      // upper triangle only, the mirror half is folded in by doubling
      for (int i = 0; i < NUM_ELEMS; i++) begin
         for (int j = i; j < NUM_ELEMS; j++) begin
            prod = a[i] * a[j];
            if (i == j) begin
               grid[i+j][2*i]     = col_t'(prod[WORD_LEN-1:0]);
               grid[i+j+1][2*i+1] = col_t'(prod[PROD_W-1:WORD_LEN]);
            end else begin
               // x2 moves the split point down one bit
               grid[i+j][2*i]     = col_t'({prod[WORD_LEN-2:0], 1'b0});
               grid[i+j+1][2*i+1] = col_t'(prod[PROD_W-1:WORD_LEN-1]);
            end
         end
      end
   end

   // 3:2 compressor chain down each column
   always_comb begin
      col_t c;
      col_t s;
      col_t cy;
      for (int col = 0; col < GRID_SIZE; col++) begin
         c = '0;
         s = '0;
         for (int r = 0; r < NUM_ROWS; r++) begin
            cy = (s & c) | (s & grid[col][r]) | (c & grid[col][r]);
            s  = s ^ c ^ grid[col][r];
            c  = cy << 1;
         end
         col_c[col] = c;
         col_s[col] = s;
      end
   end

endmodule

// ==== source/carry_normalizer.sv ====
`timescale 1ns/10ps
`include "modsq_settings.svh"

module carry_normalizer import modsq_pkg::*; #(
   parameter int NUM_COLS = 12
) (
   input  col_t  col_c[NUM_COLS],
   input  col_t  col_s[NUM_COLS],
   output limb_t limbs[NUM_COLS]
);

   localparam int WORD_LEN = `MODSQ_WORD_LEN;
   localparam int SUM_W    = `MODSQ_COL_BIT_LEN + 1;               // 30b column total
   localparam int PAD_W    = `MODSQ_BIT_LEN - `MODSQ_WORD_LEN;     // limb headroom

   logic [SUM_W-1:0] col_sum[NUM_COLS];

   always_comb begin
      for (int k = 0; k < NUM_COLS; k++) begin
         col_sum[k] = {1'b0, col_c[k]} + {1'b0, col_s[k]};
      end

      // only one hop of carry, the rest stays redundant in bit 16
      limbs[0] = {{PAD_W{1'b0}}, col_sum[0][WORD_LEN-1:0]};
      for (int k = 1; k < NUM_COLS - 1; k++) begin
         limbs[k] = {{PAD_W{1'b0}}, col_sum[k][WORD_LEN-1:0]} +
                    limb_t'(col_sum[k-1][SUM_W-1:WORD_LEN]);
      end

      // top limb keeps its own upper bit
      limbs[NUM_COLS-1] = col_sum[NUM_COLS-1][`MODSQ_BIT_LEN-1:0] +
                          limb_t'(col_sum[NUM_COLS-2][SUM_W-1:WORD_LEN]);
   end

endmodule

// ==== source/reduction_rom.sv ====
`timescale 1ns/10ps
`include "modsq_settings.svh"

module reduction_rom import modsq_pkg::*; (
   input  logic       clk,
   input  logic       msb_sel,
   input  logic       hold_lsb,
   input  limb_view_u upper[`MODSQ_NUM_LUTS],
   output limb_t      lsb_res[`MODSQ_NUM_LUTS][`MODSQ_NONRED_ELEMS],
   output limb_t      msb_res[`MODSQ_NUM_LUTS][`MODSQ_NONRED_ELEMS]
);

   localparam int NUM_LUTS    = `MODSQ_NUM_LUTS;
   localparam int NONRED      = `MODSQ_NONRED_ELEMS;
   localparam int WORD_LEN    = `MODSQ_WORD_LEN;
   localparam int ENTRY_W     = WORD_LEN * NONRED;                      // 64b residue
   localparam int MSB_W       = `MODSQ_BIT_LEN - `MODSQ_LUT_WIDTH;      // 9b
   localparam int ADDR_W      = MSB_W + 1;                              // msb half on top
   localparam int HALF_SIZE   = 1 << MSB_W;
   localparam logic [ENTRY_W-1:0] MODULUS = `MODSQ_MODULUS;

   logic [ENTRY_W-1:0] table_mem[NUM_LUTS][1 << ADDR_W];
   logic [ADDR_W-1:0]  rd_addr[NUM_LUTS];
   logic [ENTRY_W-1:0] rd_data[NUM_LUTS];
   logic [ENTRY_W-1:0] lsb_hold[NUM_LUTS];

   // both inputs already below the modulus
   function automatic logic [ENTRY_W-1:0] mod_add(input logic [ENTRY_W-1:0] x,
                                                  input logic [ENTRY_W-1:0] y);
      logic [ENTRY_W:0] sum;
      sum = {1'b0, x} + {1'b0, y};
      if (sum >= {1'b0, MODULUS}) begin
         sum = sum - {1'b0, MODULUS};
      end
      return sum[ENTRY_W-1:0];
   endfunction

   // table k covers word k+4, lower half v*2^(16(k+4)), upper half shifted 8 more
   initial begin
      logic [ENTRY_W-1:0] base;
      logic [ENTRY_W-1:0] step;
      logic [ENTRY_W-1:0] acc;
      base = ENTRY_W'(1);
      for (int e = 0; e < ENTRY_W; e++) base = mod_add(base, base);
      for (int k = 0; k < NUM_LUTS; k++) begin
         for (int half = 0; half < 2; half++) begin
            step = base;
            if (half == 1) begin
               for (int e = 0; e < `MODSQ_LUT_WIDTH; e++) step = mod_add(step, step);
            end
            acc = '0;
            for (int v = 0; v < HALF_SIZE; v++) begin
               table_mem[k][half*HALF_SIZE+v] = acc;
               acc = mod_add(acc, step);
            end
         end
         for (int e = 0; e < WORD_LEN; e++) base = mod_add(base, base);
      end
   end

   always_comb begin
      for (int k = 0; k < NUM_LUTS; k++) begin
         rd_addr[k] = msb_sel ? {1'b1, upper[k].idx.msb} : {2'b00, upper[k].idx.lsb};
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < NUM_LUTS; k++) begin
         rd_data[k] <= table_mem[k][rd_addr[k]];
         if (hold_lsb) lsb_hold[k] <= rd_data[k];   // frees the port for the msb read
      end
   end

   always_comb begin
      for (int k = 0; k < NUM_LUTS; k++) begin
         for (int w = 0; w < NONRED; w++) begin
            lsb_res[k][w] = limb_t'(lsb_hold[k][w*WORD_LEN +: WORD_LEN]);
            msb_res[k][w] = limb_t'(rd_data[k][w*WORD_LEN +: WORD_LEN]);
         end
      end
   end

endmodule

// ==== source/residue_accumulator.sv ====
`timescale 1ns/10ps
`include "modsq_settings.svh"

module residue_accumulator import modsq_pkg::*; (
   input  logic  clk,
   input  logic  load_out,
   input  limb_t low_limbs[`MODSQ_NONRED_ELEMS],
   input  limb_t lsb_res[`MODSQ_NUM_LUTS][`MODSQ_NONRED_ELEMS],
   input  limb_t msb_res[`MODSQ_NUM_LUTS][`MODSQ_NONRED_ELEMS],
   output limb_t sq_out[`MODSQ_NUM_ELEMS]
);

   localparam int NUM_ELEMS  = `MODSQ_NUM_ELEMS;
   localparam int NONRED     = `MODSQ_NONRED_ELEMS;
   localparam int NUM_LUTS   = `MODSQ_NUM_LUTS;
   localparam int STACK_SIZE = 2 * NUM_LUTS + 1;   // lsb, msb residues and the low limb

   col_t  stack[NONRED][STACK_SIZE];
   col_t  acc_c[NUM_ELEMS];
   col_t  acc_s[NUM_ELEMS];
   limb_t acc_limbs[NUM_ELEMS];

   always_comb begin
      for (int j = 0; j < NONRED; j++) begin
         stack[j][0] = col_t'(low_limbs[j]);
         for (int k = 0; k < NUM_LUTS; k++) begin
            stack[j][1+k]          = col_t'(lsb_res[k][j]);
            stack[j][1+NUM_LUTS+k] = col_t'(msb_res[k][j]);
         end
      end
   end

   // two top columns stay empty and only catch carries
   always_comb begin
      col_t c;
      col_t s;
      col_t cy;
      for (int j = 0; j < NUM_ELEMS; j++) begin
         acc_c[j] = '0;
         acc_s[j] = '0;
      end
      for (int j = 0; j < NONRED; j++) begin
         c = '0;
         s = '0;
         for (int r = 0; r < STACK_SIZE; r++) begin
            cy = (s & c) | (s & stack[j][r]) | (c & stack[j][r]);
            s  = s ^ c ^ stack[j][r];
            c  = cy << 1;
         end
         acc_c[j] = c;
         acc_s[j] = s;
      end
   end

   carry_normalizer #(.NUM_COLS(NUM_ELEMS)) u_acc_norm (
      .col_c (acc_c),
      .col_s (acc_s),
      .limbs (acc_limbs)
   );

   always_ff @(posedge clk) begin
      if (load_out) sq_out <= acc_limbs;   // held until the next C2
   end

endmodule

// ==== source/modular_square.sv ====
`timescale 1ns/10ps
`include "modsq_settings.svh"

module modular_square import modsq_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  start,
   input  limb_t sq_in[`MODSQ_NUM_ELEMS],
   output limb_t sq_out[`MODSQ_NUM_ELEMS],
   output logic  valid
);

   localparam int NUM_ELEMS = `MODSQ_NUM_ELEMS;
   localparam int NONRED    = `MODSQ_NONRED_ELEMS;
   localparam int GRID_SIZE = `MODSQ_GRID_SIZE;
   localparam int NUM_LUTS  = `MODSQ_NUM_LUTS;

   limb_t      sq_in_d1[NUM_ELEMS];
   limb_t      curr_sq[NUM_ELEMS];
   col_t       grid_c[GRID_SIZE];
   col_t       grid_s[GRID_SIZE];
   limb_t      grid_limbs[GRID_SIZE];
   limb_t      low_limbs[NONRED];
   limb_view_u upper[NUM_LUTS];
   limb_t      lsb_res[NUM_LUTS][NONRED];
   limb_t      msb_res[NUM_LUTS][NONRED];

   logic msb_sel;
   logic hold_lsb;
   logic load_out;
   logic use_input;

   modsq_sequencer u_seq (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .msb_sel   (msb_sel),
      .hold_lsb  (hold_lsb),
      .load_out  (load_out),
      .use_input (use_input),
      .valid     (valid)
   );

   // use_input is still low on the accepting edge, so a long start pulse
   // cannot disturb the operand mid-iteration
   always_ff @(posedge clk) begin
      if (start && !use_input) sq_in_d1 <= sq_in;
   end

   always_comb begin
      for (int k = 0; k < NUM_ELEMS; k++) begin
         curr_sq[k] = use_input ? sq_in_d1[k] : sq_out[k];   // loopback
      end
   end

   squaring_grid u_grid (
      .a     (curr_sq),
      .col_c (grid_c),
      .col_s (grid_s)
   );

   carry_normalizer #(.NUM_COLS(GRID_SIZE)) u_grid_norm (
      .col_c (grid_c),
      .col_s (grid_s),
      .limbs (grid_limbs)
   );

   // grid input is steady through C0 and C1, so the C0 value is still held in C2
   always_ff @(posedge clk) begin
      for (int k = 0; k < NONRED; k++) begin
         low_limbs[k] <= grid_limbs[k];
      end
   end

   always_comb begin
      for (int k = 0; k < NUM_LUTS; k++) begin
         upper[k].limb = grid_limbs[k+NONRED];   // words at and above 2^64
      end
   end

   reduction_rom u_rom (
      .clk      (clk),
      .msb_sel  (msb_sel),
      .hold_lsb (hold_lsb),
      .upper    (upper),
      .lsb_res  (lsb_res),
      .msb_res  (msb_res)
   );

   residue_accumulator u_acc (
      .clk       (clk),
      .load_out  (load_out),
      .low_limbs (low_limbs),
      .lsb_res   (lsb_res),
      .msb_res   (msb_res),
      .sq_out    (sq_out)
   );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 10
) (
   input  logic reset_req,
   output logic clk,
   output logic reset
);

   int reset_count;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial reset_count = RESET_CYCLES;   // power-on reset

   // a request restarts the full reset window
   always @(posedge clk) begin
      if (reset_req) begin
         reset_count <= RESET_CYCLES;
      end else if (reset_count > 0) begin
         reset_count <= reset_count - 1;
      end
   end

   assign reset = (reset_count != 0);

endmodule

// ==== tb/modular_square_checker.sv ====
`timescale 1ns/10ps

module modular_square_checker (
   input logic clk,
   input logic reset,
   input logic valid
);

   // three states per result, so two pulses never touch
   valid_single_cycle: assert property (
      @(posedge clk) disable iff (reset) valid |=> !valid
   ) else $error("valid stayed high for two cycles");

   // synchronous reset clears valid on the following edge
   valid_cleared_by_reset: assert property (
      @(posedge clk) reset |=> !valid
   ) else $error("valid high while reset is applied");

   // free-running loopback, a new result every third cycle
   valid_cadence: assert property (
      @(posedge clk) disable iff (reset) valid |-> ##3 valid
   ) else $error("valid did not return three cycles later");

endmodule

bind modular_square modular_square_checker u_checker (
   .clk   (clk),
   .reset (reset),
   .valid (valid)
);

// ==== tb/modular_square_tb.sv ====
`timescale 1ns/10ps
`include "modsq_settings.svh"

module modular_square_tb import modsq_pkg::*; ();

   localparam int NUM_ELEMS       = `MODSQ_NUM_ELEMS;
   localparam int WORD_LEN        = `MODSQ_WORD_LEN;
   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 10;
   localparam int VALID_GAP       = 3;
   localparam int NUM_FIXED       = 6;
   localparam int NUM_RANDOM      = 4;
   localparam int NUM_ROWS        = NUM_FIXED + NUM_RANDOM;
   localparam int MAX_ITERS       = 6;
   localparam int WATCHDOG_CYCLES = 2 * NUM_ROWS * (RESET_CYCLES + VALID_GAP * (MAX_ITERS + 2));
   localparam logic [255:0] MODULUS = 256'(`MODSQ_MODULUS);

   logic  clk;
   logic  reset;
   logic  reset_req;
   logic  start;
   logic  valid;
   limb_t sq_in[NUM_ELEMS];
   limb_t sq_out[NUM_ELEMS];

   string       row_name[NUM_ROWS];
   limb_t       row_limbs[NUM_ROWS][NUM_ELEMS];
   int          row_iters[NUM_ROWS];
   logic [31:0] rng_state;
   int          value_errors;
   int          flag_errors;
   int          other_errors;

   tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
      .reset_req (reset_req),
      .clk       (clk),
      .reset     (reset)
   );

   modular_square u_dut (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // limbs overlap by one bit, the integer is the plain radix-2^16 sum
   function automatic logic [255:0] vector_value(input limb_t v[NUM_ELEMS]);
      logic [255:0] acc;
      acc = '0;
      for (int k = 0; k < NUM_ELEMS; k++) begin
         acc = acc + (256'(v[k]) << (WORD_LEN * k));
      end
      return acc;
   endfunction

   task automatic check_residue(input string name, input logic [255:0] expected,
                                input limb_t actual[NUM_ELEMS]);
      logic [255:0] reduced;
      reduced = vector_value(actual) % MODULUS;
      if (reduced !== expected) begin
         $display("[ERROR] %s: expected %h, actual %h", name, expected[63:0], reduced[63:0]);
         value_errors++;
      end
   endtask

   task automatic check_limb(input string name, input limb_t expected, input limb_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
         flag_errors++;
      end
   endtask

   task automatic set_row(input int r, input string name,
                          input limb_t l5, l4, l3, l2, l1, l0, input int iters);
      row_name[r]     = name;
      row_iters[r]    = iters;
      row_limbs[r][0] = l0;
      row_limbs[r][1] = l1;
      row_limbs[r][2] = l2;
      row_limbs[r][3] = l3;
      row_limbs[r][4] = l4;
      row_limbs[r][5] = l5;
   endtask

   task automatic build_table();
      set_row(0, "zero", 0, 0, 0, 0, 0, 0, 3);
      set_row(1, "one", 0, 0, 0, 0, 0, 1, 3);
      set_row(2, "n_minus_one", 0, 0, 'hFFFF, 'hFFFF, 'hFFFF, 'hFFC4, 3);
      set_row(3, "three", 0, 0, 0, 0, 0, 3, MAX_ITERS);
      set_row(4, "redundant_bits", 'h0_7FFF, 'h1_ABCD, 'h1_0000, 'h0_1234, 'h1_FFFF,
              'h1_8001, 4);
      set_row(5, "above_modulus", 0, 1, 'hFFFF, 'hFFFF, 'hFFFF, 'hFFFF, 4);
      for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
         row_name[r]  = $sformatf("random_%0d", r - NUM_FIXED);
         row_iters[r] = 5;
         for (int k = 0; k < NUM_ELEMS; k++) begin
            rng_state = xorshift32(rng_state);
            // top limb stays small so the square fits the twelve grid limbs
            row_limbs[r][k] = (k == NUM_ELEMS - 1) ? limb_t'(rng_state[14:0]) : rng_state[16:0];
         end
      end
   endtask

   task automatic apply_reset(input string name);
      @(posedge clk);
      #1;
      reset_req = 1'b1;
      @(posedge clk);
      #1;
      reset_req = 1'b0;
      do begin
         @(negedge clk);
         check_limb({name, " valid in reset"}, '0, limb_t'(valid));
      end while (reset);
   endtask

   task automatic run_row(input int r);
      logic [255:0] expected;
      limb_t        held[NUM_ELEMS];
      int           cycles;
      string        tag;
      repeat (2) begin
         @(negedge clk);
         check_limb({row_name[r], " valid in idle"}, '0, limb_t'(valid));
      end
      @(posedge clk);
      #1;
      start = 1'b1;
      for (int k = 0; k < NUM_ELEMS; k++) sq_in[k] = row_limbs[r][k];
      @(posedge clk);   // start taken in idle
      #1;
      start = 1'b0;
      expected = vector_value(sq_in) % MODULUS;
      for (int it = 1; it <= row_iters[r]; it++) begin
         tag      = $sformatf("%s iter %0d", row_name[r], it);
         expected = (expected * expected) % MODULUS;   // both below 2^64
         cycles   = 0;
         do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (!valid && it > 1) begin
               for (int k = 0; k < NUM_ELEMS; k++) begin
                  check_limb({tag, " sq_out held"}, held[k], sq_out[k]);
               end
            end
         end while (!valid && cycles < 2 * VALID_GAP);
         if (!valid) begin
            $display("%s: no valid pulse within %0d cycles", tag, cycles);
            other_errors++;
         end
         check_limb({tag, " valid spacing"}, limb_t'(VALID_GAP), limb_t'(cycles));
         check_residue(tag, expected, sq_out);
         for (int k = 0; k < NUM_ELEMS; k++) held[k] = sq_out[k];
      end
   endtask

   initial begin
      reset_req    = 1'b0;
      start        = 1'b0;
      value_errors = 0;
      flag_errors  = 0;
      other_errors = 0;
      rng_state    = 32'h28b2;
      for (int k = 0; k < NUM_ELEMS; k++) sq_in[k] = '0;
      build_table();
      for (int r = 0; r < NUM_ROWS; r++) begin
         apply_reset(row_name[r]);
         run_row(r);
      end
      $display("errors: %0d value, %0d flag, %0d other", value_errors, flag_errors,
               other_errors);
      if (value_errors + flag_errors + other_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // bound from the table size, with twice the needed cycles
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== modular_square.f ====
+incdir+source
source/modsq_pkg.sv
source/modsq_sequencer.sv
source/squaring_grid.sv
source/carry_normalizer.sv
source/reduction_rom.sv
source/residue_accumulator.sv
source/modular_square.sv
tb/tb_clock_gen.sv
tb/modular_square_checker.sv
tb/modular_square_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := modular_square_tb
FILELIST  := modular_square.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
